// ==== filelist.f ====
+incdir+include
logic/policer_pkg.sv
logic/beat_if.sv
logic/frame_tracker.sv
logic/leak_timer.sv
logic/token_buckets.sv
logic/mark_stage.sv
logic/packet_policer.sv
sim/policer_checker.sv
sim/policer_tb.sv

// ==== Bender.yml ====
package:
  name: packet_policer

export_include_dirs:
  - include

sources:
  # synthesizable design, top level packet_policer
  - target: any(rtl, simulation)
    include_dirs:
      - include
    files:
      - logic/policer_pkg.sv
      - logic/beat_if.sv
      - logic/frame_tracker.sv
      - logic/leak_timer.sv
      - logic/token_buckets.sv
      - logic/mark_stage.sv
      - logic/packet_policer.sv

  # testbench, top level policer_tb
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/policer_checker.sv
      - sim/policer_tb.sv

// ==== sim/policer_tb.sv ====
//////////////////////////////
// policer testbench
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "policer_params.svh"

module policer_tb;

    localparam int RESET_CYCLES = 16;
    localparam int MARGIN       = 50;

    typedef struct packed {
        logic [7:0]                    test;
        policer_pkg::port_t            port;
        policer_pkg::len_t             length;
        logic [7:0]                    beats;
        logic [7:0]                    gap;      // idle cycles after the packet
        logic [`POLICER_NUM_PORTS-1:0] enable;
        policer_pkg::decrement_t       dec;      // applied to the row's port
        policer_pkg::threshold_t       thr;      // applied to the row's port
    } row_t;

    logic                          packet_in;
    logic                          reset;
    logic                          in_valid;
    policer_pkg::data_t            in_data;
    logic                          in_last;
    policer_pkg::port_t            in_port;
    policer_pkg::len_t             in_length;
    logic [`POLICER_NUM_PORTS-1:0] enable;
    policer_pkg::decrement_t       decrement [`POLICER_NUM_PORTS-1:0];
    policer_pkg::threshold_t       threshold [`POLICER_NUM_PORTS-1:0];
    logic                          out_valid;
    policer_pkg::data_t            out_data;
    logic                          out_last;
    policer_pkg::port_t            out_port;
    policer_pkg::len_t             out_length;
    logic                          out_drop;

    int   test_id;
    logic finish_run;
    int   error_count;
    int   cycle_count = 0;
    int   cycle_limit = 1000000;    // replaced once the table is loaded
    row_t rows [$];

    initial packet_in = 1'b0;
    always #10 packet_in = ~packet_in;

    packet_policer dut0 (
        .packet_in (packet_in), .reset (reset),
        .in_valid (in_valid), .in_data (in_data), .in_last (in_last),
        .in_port (in_port), .in_length (in_length),
        .enable (enable), .decrement (decrement), .threshold (threshold),
        .out_valid (out_valid), .out_data (out_data), .out_last (out_last),
        .out_port (out_port), .out_length (out_length), .out_drop (out_drop)
    );

    policer_checker chk0 (
        .packet_in (packet_in), .reset (reset),
        .in_valid (in_valid), .in_data (in_data), .in_last (in_last),
        .in_port (in_port), .in_length (in_length),
        .enable (enable), .decrement (decrement), .threshold (threshold),
        .out_valid (out_valid), .out_data (out_data), .out_last (out_last),
        .out_port (out_port), .out_length (out_length), .out_drop (out_drop),
        .test_id (test_id), .finish_run (finish_run), .error_count (error_count)
    );

    task automatic add_row(input int test, input int port, input int length, input int beats,
                           input int gap, input logic [`POLICER_NUM_PORTS-1:0] en,
                           input int dec, input int thr);
        row_t r;
        r.test   = test;
        r.port   = port;
        r.length = length;
        r.beats  = beats;
        r.gap    = gap;
        r.enable = en;
        r.dec    = dec;
        r.thr    = thr;
        rows.push_back(r);
    endtask

    task automatic load_table();
        // test, port, length, beats, gap, enable, decrement, threshold
        add_row(2, 0, 100, 3,  0, 4'b1111, 'h00000, 1000);
        add_row(2, 0,  60, 1,  1, 4'b1111, 'h00000, 1000);
        add_row(2, 0, 200, 4,  2, 4'b1111, 'h00000, 1000);
        add_row(3, 1, 120, 2,  0, 4'b1111, 'h00000, 300);
        add_row(3, 1, 120, 2,  0, 4'b1111, 'h00000, 300);
        add_row(3, 1, 120, 2,  0, 4'b1111, 'h00000, 300);   // 360 is over 300
        add_row(3, 1,  50, 1,  0, 4'b1111, 'h00000, 300);
        add_row(3, 1,  20, 1,  3, 4'b1111, 'h00000, 300);   // 310 is over 300
        add_row(4, 1, 100, 2, 40, 4'b1111, 'h01480, 300);   // leak of 20.5 per tick
        add_row(4, 1, 100, 2, 60, 4'b1111, 'h01480, 300);   // long gap drains to zero
        add_row(4, 1, 250, 3,  2, 4'b1111, 'h01480, 300);
        add_row(5, 2,  60, 1,  0, 4'b1111, 'h00000, 100);   // level 60 before port 2 goes off
        add_row(5, 2, 150, 3,  0, 4'b1011, 'h00000, 100);   // port 2 off
        add_row(5, 2, 150, 1,  1, 4'b1011, 'h00000, 100);
        add_row(5, 2,  80, 2,  0, 4'b1111, 'h00000, 100);   // back on, starts empty
        add_row(5, 2,  30, 1,  1, 4'b1111, 'h00000, 100);
        add_row(6, 3,  40, 1,  0, 4'b1111, 'h00000, 50);
        add_row(6, 0, 500, 2,  0, 4'b1111, 'h00000, 1000);
        add_row(6, 3,  20, 1,  0, 4'b1111, 'h00000, 50);
        add_row(6, 2,  10, 1,  0, 4'b1111, 'h00000, 100);
        add_row(6, 1, 200, 2,  0, 4'b1111, 'h01480, 300);
        add_row(6, 0, 200, 3,  0, 4'b1111, 'h00000, 1000);
        add_row(6, 3,  10, 1,  0, 4'b1111, 'h00000, 50);    // exactly at the limit
        add_row(6, 2,  20, 1,  2, 4'b1111, 'h00000, 100);
    endtask

    // port controls change together with the head beat on the falling edge
    task automatic send_row(input row_t r);
        enable            = r.enable;
        decrement[r.port] = r.dec;
        threshold[r.port] = r.thr;
        test_id           = r.test;
        for (int b = 0; b < r.beats; b++) begin
            in_valid  = 1'b1;
            in_data   = $urandom();
            in_last   = (b == r.beats - 1);
            in_port   = r.port;
            in_length = r.length;
            @(negedge packet_in);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
        repeat (r.gap) @(negedge packet_in);
    endtask

    always @(posedge packet_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles before the table was done", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b1;  // a full-length head beat is held during reset
        in_data    = '0;
        in_last    = 1'b1;
        in_port    = '0;
        in_length  = '1;
        enable     = '1;
        test_id    = 1;     // reset phase
        finish_run = 1'b0;
        foreach (decrement[p]) begin
            decrement[p] = '0;
            threshold[p] = '0;  // the reset beat is over every limit
        end
        void'($urandom(32'hb6a3));
        load_table();
        cycle_limit = RESET_CYCLES + MARGIN;
        foreach (rows[i]) begin
            cycle_limit += rows[i].beats + rows[i].gap;
        end
        repeat (RESET_CYCLES) @(negedge packet_in);
        reset = 1'b0;
        foreach (rows[i]) begin
            send_row(rows[i]);
        end
        repeat (3) @(negedge packet_in);    // let the last beat leave
        finish_run = 1'b1;
        #1;
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/policer_checker.sv ====
//////////////////////////////
// policer output checker
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "policer_params.svh"

module policer_checker (
    input  logic                          packet_in,
    input  logic                          reset,
    input  logic                          in_valid,
    input  policer_pkg::data_t            in_data,
    input  logic                          in_last,
    input  policer_pkg::port_t            in_port,
    input  policer_pkg::len_t             in_length,
    input  logic [`POLICER_NUM_PORTS-1:0] enable,
    input  policer_pkg::decrement_t       decrement [`POLICER_NUM_PORTS-1:0],
    input  policer_pkg::threshold_t       threshold [`POLICER_NUM_PORTS-1:0],
    input  logic                          out_valid,
    input  policer_pkg::data_t            out_data,
    input  logic                          out_last,
    input  policer_pkg::port_t            out_port,
    input  policer_pkg::len_t             out_length,
    input  logic                          out_drop,
    input  int                            test_id,
    input  logic                          finish_run,
    output int                            error_count
);

    longint             bucket [`POLICER_NUM_PORTS];   // level in 1/256 byte units
    longint             cycle;          // cycles since reset release
    logic               in_packet;      // a packet has opened but not closed
    logic               armed = 1'b0;   // first reset edge seen
    logic               exp_valid;
    policer_pkg::data_t exp_data;
    logic               exp_last;
    policer_pkg::port_t exp_port;
    policer_pkg::len_t  exp_length;
    logic               exp_drop;
    int                 exp_test;       // test that owns the predicted beat
    int                 shown_test;     // test whose line is still open
    int                 checks = 0;
    int                 tests_done = 0;
    int                 test_beats [16] = '{default: 0};
    int                 test_drops [16] = '{default: 0};
    int                 test_errs  [16] = '{default: 0};

    initial error_count = 0;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            error_count++;
            test_errs[exp_test]++;
            $display("error: %s is %h, expected %h (test %0d at %0t)",
                     name, got, want, exp_test, $time);
        end
    endtask

    task automatic report_test(input int t);
        tests_done++;
        $display("test %0d: %0d beats, %0d marked, %0d errors, %s", t, test_beats[t],
                 test_drops[t], test_errs[t], (test_errs[t] == 0) ? "ok" : "mismatch");
    endtask

    // outputs are compared at the edge after their beat, then the next beat is predicted
    always @(posedge packet_in) begin : model
        logic   tick;
        logic   head;
        logic   drop_next;
        longint level;
        if (armed) begin
            if (exp_test != shown_test) begin
                report_test(shown_test);
                shown_test = exp_test;
            end
            compare_value("out_valid", out_valid, exp_valid);
            compare_value("out_last", out_last, exp_last);
            compare_value("out_drop", out_drop, exp_drop);
            if (exp_valid) begin
                compare_value("out_data", out_data, exp_data);
                compare_value("out_port", out_port, exp_port);
                compare_value("out_length", out_length, exp_length);
                test_beats[exp_test]++;
                test_drops[exp_test] += exp_drop;
            end
        end
        if (reset) begin
            if (!armed) begin
                shown_test = test_id;
            end
            armed     = 1'b1;
            cycle     = 0;
            in_packet = 1'b0;
            foreach (bucket[p]) begin
                bucket[p] = 0;
            end
            exp_valid = 1'b0;
            exp_last  = 1'b0;
            exp_drop  = 1'b0;
        end else begin
            tick      = (cycle % `POLICER_LEAK_PERIOD) == (`POLICER_LEAK_PERIOD - 1);
            head      = in_valid && !in_packet;
            drop_next = 1'b0;
            for (int p = 0; p < `POLICER_NUM_PORTS; p++) begin
                level = bucket[p];
                if (!enable[p]) begin
                    level = 0;      // disabled port stays empty
                end else begin
                    if (head && in_port == p) begin
                        if ((level >> `POLICER_FRAC_BITS) + longint'(in_length) >
                            longint'(threshold[p])) begin
                            drop_next = 1'b1;
                        end else begin
                            level = level + (longint'(in_length) << `POLICER_FRAC_BITS);
                        end
                    end
                    if (tick) begin
                        level = (level > longint'(decrement[p])) ?
                                level - longint'(decrement[p]) : 0;
                    end
                end
                bucket[p] = level;
            end
            if (in_valid) begin
                in_packet = !in_last;
            end
            cycle++;
            exp_valid  = in_valid;
            exp_data   = in_data;
            exp_last   = in_last;
            exp_port   = in_port;
            exp_length = in_length;
            exp_drop   = drop_next;
        end
        exp_test = test_id;
    end

    always @(posedge finish_run) begin
        report_test(shown_test);
        $display("totals: %0d tests, %0d checks, %0d errors", tests_done, checks, error_count);
    end

endmodule

`default_nettype wire

// ==== logic/packet_policer.sv ====
//////////////////////////////
// ingress packet policer
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "policer_params.svh"

module packet_policer (
    input  logic                     packet_in,
    input  logic                     reset,

    input  logic                     in_valid,
    input  policer_pkg::data_t       in_data,
    input  logic                     in_last,
    input  policer_pkg::port_t       in_port,
    input  policer_pkg::len_t        in_length,

    input  logic [`POLICER_NUM_PORTS-1:0] enable,
    input  policer_pkg::decrement_t  decrement [`POLICER_NUM_PORTS-1:0],
    input  policer_pkg::threshold_t  threshold [`POLICER_NUM_PORTS-1:0],

    output logic                     out_valid,
    output policer_pkg::data_t       out_data,
    output logic                     out_last,
    output policer_pkg::port_t       out_port,
    output policer_pkg::len_t        out_length,
    output logic                     out_drop
);

    logic head;         // first beat of a packet
    logic leak_tick;
    logic drop;         // decision for last cycle's head beat

    beat_if in_beat ();

    // source side of the bundle
    assign in_beat.valid  = in_valid;
    assign in_beat.data   = in_data;
    assign in_beat.last   = in_last;
    assign in_beat.port   = in_port;
    assign in_beat.length = in_length;

    frame_tracker u_frame_tracker (
        .packet_in (packet_in),
        .reset     (reset),
        .beat      (in_beat.sink),
        .head      (head)
    );

    leak_timer u_leak_timer (
        .packet_in (packet_in),
        .reset     (reset),
        .leak_tick (leak_tick)
    );

    token_buckets u_token_buckets (
        .packet_in (packet_in),
        .reset     (reset),
        .beat      (in_beat.sink),
        .head      (head),
        .leak_tick (leak_tick),
        .enable    (enable),
        .decrement (decrement),
        .threshold (threshold),
        .drop      (drop)
    );

    mark_stage u_mark_stage (
        .packet_in  (packet_in),
        .reset      (reset),
        .beat       (in_beat.sink),
        .drop       (drop),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_port   (out_port),
        .out_length (out_length),
        .out_drop   (out_drop)
    );

endmodule

`default_nettype wire

// ==== logic/mark_stage.sv ====
//////////////////////////////
// output beat register
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mark_stage (
    input  logic               packet_in,
    input  logic               reset,
    beat_if.sink               beat,
    input  logic               drop,
    output logic               out_valid,
    output policer_pkg::data_t out_data,
    output logic               out_last,
    output policer_pkg::port_t out_port,
    output policer_pkg::len_t  out_length,
    output logic               out_drop
);

    // flags that qualify the beat
    always_ff @(posedge packet_in) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= beat.valid;
            out_last  <= beat.last;
        end
    end

    // payload and tags, meaningful only with out_valid
    always_ff @(posedge packet_in) begin
        out_data   <= beat.data;
        out_port   <= beat.port;
        out_length <= beat.length;
    end

    // The bucket decision is registered on the same edge as the beat
    // above, so it already lines up with the head beat at the output.
    assign out_drop = drop;

endmodule

`default_nettype wire

// ==== logic/token_buckets.sv ====
//////////////////////////////
// per-port token buckets
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "policer_params.svh"

module token_buckets (
    input  logic                     packet_in,
    input  logic                     reset,
    beat_if.sink                     beat,
    input  logic                     head,
    input  logic                     leak_tick,
    input  logic [`POLICER_NUM_PORTS-1:0] enable,
    input  policer_pkg::decrement_t  decrement [`POLICER_NUM_PORTS-1:0],
    input  policer_pkg::threshold_t  threshold [`POLICER_NUM_PORTS-1:0],
    output logic                     drop
);

    localparam int NPORTS  = `POLICER_NUM_PORTS;
    localparam int FRAC    = `POLICER_FRAC_BITS;
    localparam int BKT_W   = $bits(policer_pkg::bucket_t);
    localparam int WHOLE_W = BKT_W - FRAC;

    policer_pkg::bucket_t bucket      [NPORTS-1:0];
    policer_pkg::bucket_t bucket_next [NPORTS-1:0];
    logic [NPORTS-1:0]    drop_hit;     // head beat over its threshold, per port

    // leak with a floor at zero
    function automatic policer_pkg::bucket_t sat_sub(
        input policer_pkg::bucket_t    level,
        input policer_pkg::decrement_t amount
    );
        policer_pkg::bucket_t wide_amount;
        wide_amount = {{(BKT_W-$bits(amount)){1'b0}}, amount};
        if (level > wide_amount) begin
            return level - wide_amount;
        end
        return '0;
    endfunction

    for (genvar p = 0; p < NPORTS; p++) begin : g_port
        logic                 hit;          // head beat addressed to this port
        logic [WHOLE_W:0]     level_sum;    // whole part plus packet length
        logic                 over;
        policer_pkg::bucket_t charged;
        policer_pkg::bucket_t base;         // level before the leak
        policer_pkg::bucket_t leaked;

        assign hit = head && (beat.port == policer_pkg::port_t'(p));

        // threshold check uses the level before this cycle's leak
        assign level_sum = {1'b0, bucket[p][BKT_W-1:FRAC]}
                         + {{(WHOLE_W+1-$bits(beat.length)){1'b0}}, beat.length};
        assign over = level_sum > {{(WHOLE_W+1-$bits(threshold[p])){1'b0}}, threshold[p]};

        assign charged = bucket[p]
                       + {{(WHOLE_W-$bits(beat.length)){1'b0}}, beat.length, {FRAC{1'b0}}};

        // a marked packet leaves the level untouched
        assign base   = (hit && !over) ? charged : bucket[p];
        assign leaked = leak_tick ? sat_sub(base, decrement[p]) : base;

        assign bucket_next[p] = enable[p] ? leaked : '0;   // disabled port is held empty
        assign drop_hit[p]    = enable[p] && hit && over;
    end

    always_ff @(posedge packet_in) begin
        if (reset) begin
            bucket <= '{default: '0};
            drop   <= 1'b0;
        end else begin
            bucket <= bucket_next;
            drop   <= |drop_hit;    // at most one head beat per cycle
        end
    end

endmodule

`default_nettype wire

// ==== logic/leak_timer.sv ====
//////////////////////////////
// leak tick timer
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "policer_params.svh"

module leak_timer (
    input  logic packet_in,
    input  logic reset,
    output logic leak_tick
);

    // at least one bit, even for a period of one
    localparam int CNT_W = ($clog2(`POLICER_LEAK_PERIOD) > 0) ?
                           $clog2(`POLICER_LEAK_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`POLICER_LEAK_PERIOD - 1);

    logic [CNT_W-1:0] count;

    // one cycle in every period, on the last count
    assign leak_tick = (count == CNT_LAST);

    always_ff @(posedge packet_in) begin
        if (reset) begin
            count <= '0;
        end else if (count == CNT_LAST) begin
            count <= '0;    // wrap
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_tracker.sv ====
//////////////////////////////
// packet head tracker
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module frame_tracker (
    input  logic   packet_in,
    input  logic   reset,
    beat_if.sink   beat,
    output logic   head
);

    policer_pkg::frame_state_t state;
    policer_pkg::frame_state_t state_next;

    // The length tag repeats on every beat of a packet, so only the
    // first one may be used to charge a bucket.
    assign head = beat.valid && (state == policer_pkg::expect_head);

    always_comb begin
        state_next = state;
        case (state)
            policer_pkg::expect_head: begin
                if (beat.valid && !beat.last) begin
                    state_next = policer_pkg::in_body;  // multi-beat packet
                end
            end
            policer_pkg::in_body: begin
                if (beat.valid && beat.last) begin
                    state_next = policer_pkg::expect_head;
                end
            end
            default: begin
                state_next = policer_pkg::expect_head;
            end
        endcase
    end

    always_ff @(posedge packet_in) begin
        if (reset) begin
            state <= policer_pkg::expect_head;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/beat_if.sv ====
//////////////////////////////
// stream beat bundle
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface beat_if;

    logic                valid;     // beat present this cycle
    policer_pkg::data_t  data;
    logic                last;      // closing beat of a packet
    policer_pkg::port_t  port;      // ingress port tag
    policer_pkg::len_t   length;    // byte length of the whole packet

    // producer side
    modport source (
        output valid, data, last, port, length
    );

    // consumer side
    modport sink (
        input valid, data, last, port, length
    );

endinterface

`default_nettype wire

// ==== logic/policer_pkg.sv ====
//////////////////////////////
// policer types
//////////////////////////////

`default_nettype none

`include "policer_params.svh"

package policer_pkg;

    // beat payload
    typedef logic [`POLICER_DATA_WIDTH-1:0] data_t;

    // ingress port index
    typedef logic [$clog2(`POLICER_NUM_PORTS)-1:0] port_t;

    // packet length in bytes
    typedef logic [`POLICER_LEN_WIDTH-1:0] len_t;

    // Leak amount per tick, whole bytes over the fraction bits.
    typedef logic [`POLICER_LEN_WIDTH+`POLICER_FRAC_BITS-1:0] decrement_t;

    // depth limit, whole bytes only
    typedef logic [`POLICER_LEN_WIDTH:0] threshold_t;

    // Bucket level. The whole part has two bits of headroom over a
    // packet length so that level plus length cannot wrap.
    typedef logic [`POLICER_LEN_WIDTH+2+`POLICER_FRAC_BITS-1:0] bucket_t;

    // frame position of the incoming beat
    typedef enum logic {
        expect_head,    // next valid beat opens a packet
        in_body         // inside a packet, waiting for last
    } frame_state_t;

endpackage

`default_nettype wire

// ==== include/policer_params.svh ====
//////////////////////////////
// policer parameters
//////////////////////////////

`ifndef POLICER_PARAMS_SVH
`define POLICER_PARAMS_SVH

// ingress ports served by the policer
`define POLICER_NUM_PORTS 4

// stream payload per beat
`define POLICER_DATA_WIDTH 32

// packet byte length tag
`define POLICER_LEN_WIDTH 12

// fixed point fraction of bucket level and decrement
`define POLICER_FRAC_BITS 8

// cycles between two leak ticks
`define POLICER_LEAK_PERIOD 4

`endif
